// File: mipsCpuBus.f
logic/isaPkg.sv
logic/busPkg.sv
logic/registerFile.sv
logic/executeUnit.sv
logic/cpuControl.sv
logic/mipsCpuBus.sv
dv/clockGen.sv
dv/mipsCpuBusTb.sv

// File: Makefile
# Verilator flow for the multi-cycle MIPS core
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
FILELIST  ?= mipsCpuBus.f
TB_TOP    ?= mipsCpuBusTb
RTL_TOP   ?= mipsCpuBus
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/100ps
RTL_SRCS  ?= $(shell grep '^logic/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

# The run passes only if the log holds the pass line
run: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -qx 'TEST RESULT: PASS' $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/program.hex
// One instruction word per line, loaded from the reset vector BFC00000
// r8 result area base BFC01000, r9 = 000000F7, r10 = FFFFFF0F, r11 result
3C08BFC0  // lui   r8, 0xbfc0
35081000  // ori   r8, r8, 0x1000
240900F7  // addiu r9, r0, 0x00f7
240AFF0F  // addiu r10, r0, 0xff0f
012A5821  // addu  r11, r9, r10
AD0B0000  // sw    r11, 0x00(r8)
012A5823  // subu  r11, r9, r10
AD0B0004  // sw    r11, 0x04(r8)
012A5824  // and   r11, r9, r10
AD0B0008  // sw    r11, 0x08(r8)
012A5825  // or    r11, r9, r10
AD0B000C  // sw    r11, 0x0c(r8)
012A5826  // xor   r11, r9, r10
AD0B0010  // sw    r11, 0x10(r8)
0149582A  // slt   r11, r10, r9
AD0B0014  // sw    r11, 0x14(r8)
0149582B  // sltu  r11, r10, r9
AD0B0018  // sw    r11, 0x18(r8)
00095900  // sll   r11, r9, 4
AD0B001C  // sw    r11, 0x1c(r8)
000A5902  // srl   r11, r10, 4
AD0B0020  // sw    r11, 0x20(r8)
000A5903  // sra   r11, r10, 4
AD0B0024  // sw    r11, 0x24(r8)
252B8000  // addiu r11, r9, 0x8000
AD0B0028  // sw    r11, 0x28(r8)
314BF0F0  // andi  r11, r10, 0xf0f0
AD0B002C  // sw    r11, 0x2c(r8)
352B8000  // ori   r11, r9, 0x8000
AD0B0030  // sw    r11, 0x30(r8)
394BFFFF  // xori  r11, r10, 0xffff
AD0B0034  // sw    r11, 0x34(r8)
292B8000  // slti  r11, r9, 0x8000
AD0B0038  // sw    r11, 0x38(r8)
2D4BFFFF  // sltiu r11, r10, 0xffff
AD0B003C  // sw    r11, 0x3c(r8)
3C0B1234  // lui   r11, 0x1234
AD0B0040  // sw    r11, 0x40(r8)
A1090050  // sb    r9, 0x50(r8)
A10A0051  // sb    r10, 0x51(r8)
A1090052  // sb    r9, 0x52(r8)
A10A0053  // sb    r10, 0x53(r8)
910B0052  // lbu   r11, 0x52(r8)
AD0B0044  // sw    r11, 0x44(r8)
8D0B0050  // lw    r11, 0x50(r8)
AD0B0048  // sw    r11, 0x48(r8)
11290001  // beq   r9, r9, +1
FFFFFFFF  // trap
340B00C1  // ori   r11, r0, 0x00c1
AD0B004C  // sw    r11, 0x4c(r8)
15290001  // bne   r9, r9, +1
0BF00035  // j     0xbfc000d4
FFFFFFFF  // trap
340B00C2  // ori   r11, r0, 0x00c2
AD0B0054  // sw    r11, 0x54(r8)
3C0DBFC0  // lui   r13, 0xbfc0
35AD00EC  // ori   r13, r13, 0x00ec
01A00008  // jr    r13
FFFFFFFF  // trap
340B00C3  // ori   r11, r0, 0x00c3
AD0B005C  // sw    r11, 0x5c(r8)
24021234  // addiu r2, r0, 0x1234
00000008  // jr    r0

// File: dv/mipsCpuBusTb.sv
`default_nettype none

module mipsCpuBusTb;

    timeunit 1ns;
    timeprecision 100ps;

    import isaPkg::*;
    import busPkg::*;

    localparam int clockPeriod = 40;
    localparam int resetCycles = 16;
    localparam int stimDelay = 2;
    localparam int programWords = 63;
    localparam int maxInstrCycles = 8;
    localparam int maxBusyRun = 3;
    localparam int watchdogNs = (programWords * maxInstrCycles + resetCycles) * clockPeriod;
    localparam int unsigned randomSeed = 32'h1ba4_ec4b;
    localparam addrT resultBase = resetVector + 32'h1000;
    localparam addrT resultSpan = 32'h60;
    localparam wordT trapWord = 32'hFFFF_FFFF;
    localparam wordT expectedV0 = 32'h0000_1234;

    localparam int testReset = 0;
    localparam int testBackPressure = 1;
    localparam int testAlu = 2;
    localparam int testByte = 3;
    localparam int testControl = 4;
    localparam int testHalt = 5;
    localparam int testCount = 6;

    logic clk;
    logic reset;
    logic active;
    wordT registerV0;
    addrT address;
    logic write;
    logic read;
    logic waitrequest;
    wordT writedata;
    byteEnT byteenable;
    wordT readdata;

    wordT image [programWords];
    wordT mem [addrT];
    wordT expected [addrT];
    bit stored [addrT];
    int failures [testCount];
    string testNames [testCount] = '{"reset", "backpressure", "alu", "byte", "control", "halt"};
    // Low bytes of r9 and r10 in the order the four sb store them
    logic [7:0] sbBytes [wordLanes] = '{8'hF7, 8'h0F, 8'hF7, 8'h0F};
    int cycles = 0;
    int byteStores = 0;
    bit firstReadSeen = 1'b0;

    clockGen #(.periodNs(clockPeriod)) clock (.clk);

    mipsCpuBus DUT (
        .clk, .reset, .active, .registerV0,
        .address, .write, .read, .waitrequest,
        .writedata, .byteenable, .readdata
    );

    task automatic recordFailure(int test, string text);
        failures[test]++;
        $display("%s (test %s, %0d ns)", text, testNames[test], $time);
    endtask

    function automatic int testOfOffset(addrT offset);
        if (offset < 32'h44)
            return testAlu;
        if (offset < 32'h4C)
            return testByte;
        return testControl;
    endfunction

    // Every address bit shows up in the pattern
    function automatic wordT fillWord(addrT addr);
        return {addr[15:0], addr[31:16]} ^ 32'hA5C3_3C5A;
    endfunction

    function automatic wordT readWord(addrT addr);
        if (mem.exists(addr))
            return mem[addr];
        return fillWord(addr);
    endfunction

    task automatic loadProgram();
        $readmemh("dv/program.hex", image);
        for (int i = 0; i < programWords; i++) begin
            mem[resetVector + addrT'(4 * i)] = image[i];
        end
    endtask

    // Result area contents worked out by hand from r9 = 0xF7 and r10 = 0xFFFFFF0F
    task automatic loadExpected();
        expected[32'h00] = 32'h0000_0006;
        expected[32'h04] = 32'h0000_01E8;
        expected[32'h08] = 32'h0000_0007;
        expected[32'h0C] = 32'hFFFF_FFFF;
        expected[32'h10] = 32'hFFFF_FFF8;
        expected[32'h14] = 32'h0000_0001;
        expected[32'h18] = 32'h0000_0000;
        expected[32'h1C] = 32'h0000_0F70;
        expected[32'h20] = 32'h0FFF_FFF0;
        expected[32'h24] = 32'hFFFF_FFF0;
        expected[32'h28] = 32'hFFFF_80F7;
        expected[32'h2C] = 32'h0000_F000;
        expected[32'h30] = 32'h0000_80F7;
        expected[32'h34] = 32'hFFFF_00F0;
        expected[32'h38] = 32'h0000_0000;
        expected[32'h3C] = 32'h0000_0001;
        expected[32'h40] = 32'h1234_0000;
        expected[32'h44] = 32'h0000_00F7;
        expected[32'h48] = 32'h0FF7_0FF7;
        expected[32'h4C] = 32'h0000_00C1;
        expected[32'h54] = 32'h0000_00C2;
        expected[32'h5C] = 32'h0000_00C3;
    endtask

    task automatic checkByteStore();
        byteEnT lane;
        wordT data;
        if (byteStores >= wordLanes) begin
            recordFailure(testByte, "more byte stores than the program issues");
            return;
        end
        lane = byteEnT'(1) << byteStores;
        data = {wordLanes{sbBytes[byteStores]}};
        assert (byteenable == lane)
            else recordFailure(testByte, $sformatf("mismatch byteenable: expected %h actual %h",
                lane, byteenable));
        assert (writedata == data)
            else recordFailure(testByte, $sformatf("mismatch writedata: expected %h actual %h",
                data, writedata));
        byteStores++;
    endtask

    task automatic checkResult(addrT offset);
        int test;
        test = testOfOffset(offset);
        stored[offset] = 1'b1;
        if (!expected.exists(offset)) begin
            recordFailure(test, $sformatf("store to unused result address %h", address));
        end else begin
            assert (writedata == expected[offset])
                else recordFailure(test,
                    $sformatf("mismatch writedata at %h: expected %h actual %h",
                    address, expected[offset], writedata));
        end
    endtask

    // Merge the enabled lanes and check what was written
    task automatic completeWrite();
        wordT merged;
        merged = readWord(address);
        for (int lane = 0; lane < wordLanes; lane++) begin
            if (byteenable[lane])
                merged[8*lane +: 8] = writedata[8*lane +: 8];
        end
        mem[address] = merged;
        if (byteenable != '1)
            checkByteStore();
        else if (address - resultBase < resultSpan)
            checkResult(address - resultBase);
    endtask

    // Memory slave with random waitrequest of at most three busy cycles in a row
    initial begin
        int busyRun;
        busyRun = 0;
        void'($urandom(randomSeed));
        waitrequest = 1'b0;
        readdata = '0;
        forever begin
            @(posedge clk);
            if (!reset && !waitrequest && write)
                completeWrite();
            if (!reset && !waitrequest && read && !firstReadSeen) begin
                firstReadSeen = 1'b1;
                assert (address == resetVector)
                    else recordFailure(testReset,
                        $sformatf("mismatch address: expected %h actual %h",
                        resetVector, address));
            end
            #stimDelay;
            if (busyRun >= maxBusyRun)
                waitrequest = 1'b0;
            else
                waitrequest = $urandom_range(4, 0) < 2;
            busyRun = waitrequest ? busyRun + 1 : 0;
            readdata = readWord(address);
        end
    end

    always @(posedge clk) cycles <= cycles + 1;

    assert property (@(posedge clk) (reset && cycles > 0) || $fell(reset)
        |-> !read && !write && active)
        else recordFailure(testReset, "bus request or halted core while in reset");

    assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=> $stable(address) && $stable(writedata)
            && $stable(byteenable) && $stable(read) && $stable(write))
        else recordFailure(testBackPressure, "bus outputs changed while waitrequest was high");

    assert property (@(posedge clk) disable iff (reset) !(read && write))
        else recordFailure(testBackPressure, "read and write high in the same cycle");

    // Trap words sit only where a correct branch or jump skips them
    assert property (@(posedge clk) disable iff (reset)
        read && !waitrequest |-> readdata != trapWord)
        else recordFailure(testControl, $sformatf("core read a trap word at %h",
            $sampled(address)));

    assert property (@(posedge clk) disable iff (reset) !active |-> !read && !write)
        else recordFailure(testHalt, "bus request after halt");

    assert property (@(posedge clk) disable iff (reset) !active |=> !active)
        else recordFailure(testHalt, "core became active again after halt");

    task automatic finalChecks();
        foreach (expected[offset]) begin
            assert (stored.exists(offset))
                else recordFailure(testOfOffset(offset),
                    $sformatf("no store reached result address %h", resultBase + offset));
        end
        assert (byteStores == wordLanes)
            else recordFailure(testByte, $sformatf("%0d byte stores seen, %0d expected",
                byteStores, wordLanes));
        assert (firstReadSeen)
            else recordFailure(testReset, "no read after reset");
        assert (registerV0 == expectedV0)
            else recordFailure(testHalt, $sformatf("mismatch registerV0: expected %h actual %h",
                expectedV0, registerV0));
    endtask

    initial begin
        int passed;
        passed = 0;
        reset = 1'b1;
        loadProgram();
        loadExpected();
        repeat (resetCycles) @(posedge clk);
        #stimDelay;
        reset = 1'b0;
        wait (!active);
        // Watch the idle bus for a few cycles
        repeat (4) @(posedge clk);
        finalChecks();
        for (int t = 0; t < testCount; t++) begin
            $display("test %-12s %s, %0d errors", testNames[t],
                failures[t] == 0 ? "passed" : "failed", failures[t]);
            if (failures[t] == 0)
                passed++;
        end
        $display("tests passed %0d, failed %0d", passed, testCount - passed);
        if (passed == testCount) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(watchdogNs);
        $display("watchdog expired, core still active after %0d ns", watchdogNs);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/clockGen.sv
`default_nettype none

module clockGen #(
    parameter int periodNs = 40
) (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    // Free running, first rising edge half a period in
    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

// File: logic/mipsCpuBus.sv
`default_nettype none

module mipsCpuBus (
    input wire clk,
    input wire reset,
    output logic active,
    output isaPkg::wordT registerV0,
    output busPkg::addrT address,
    output logic write,
    output logic read,
    input wire waitrequest,
    output isaPkg::wordT writedata,
    output busPkg::byteEnT byteenable,
    input wire isaPkg::wordT readdata
);

    import isaPkg::*;
    import busPkg::*;

    // Register file ports
    regIdxT rsIdx;
    regIdxT rtIdx;
    wordT rsData;
    wordT rtData;
    logic writeEnable;
    regIdxT writeIdx;
    wordT writeData;

    // Execute unit controls and results
    aluOpT aluOp;
    immT immediate;
    shamtT shamt;
    logic signedImm;
    logic useImm;
    logic isBne;
    addrT pc;
    wordT aluResult;
    logic branchTaken;
    addrT branchTarget;

    cpuControl control (
        .clk, .reset, .active,
        .address, .read, .write, .waitrequest,
        .writedata, .byteenable, .readdata,
        .rsIdx, .rtIdx, .rsData, .rtData,
        .writeEnable, .writeIdx, .writeData,
        .aluOp, .immediate, .shamt, .signedImm, .useImm, .isBne,
        .pc, .aluResult, .branchTaken, .branchTarget
    );

    registerFile regs (
        .clk, .reset,
        .rsIdx, .rtIdx, .rsData, .rtData,
        .writeEnable, .writeIdx, .writeData,
        .registerV0
    );

    executeUnit execute (
        .aluOp, .rsData, .rtData,
        .immediate, .shamt, .signedImm, .useImm,
        .pc, .isBne,
        .aluResult, .branchTaken, .branchTarget
    );

endmodule

`default_nettype wire

// File: logic/cpuControl.sv
`default_nettype none

module cpuControl (
    input wire clk,
    input wire reset,
    output logic active,
    output busPkg::addrT address,
    output logic read,
    output logic write,
    input wire waitrequest,
    output isaPkg::wordT writedata,
    output busPkg::byteEnT byteenable,
    input wire isaPkg::wordT readdata,
    output isaPkg::regIdxT rsIdx,
    output isaPkg::regIdxT rtIdx,
    input wire isaPkg::wordT rsData,
    input wire isaPkg::wordT rtData,
    output logic writeEnable,
    output isaPkg::regIdxT writeIdx,
    output isaPkg::wordT writeData,
    output isaPkg::aluOpT aluOp,
    output isaPkg::immT immediate,
    output isaPkg::shamtT shamt,
    output logic signedImm,
    output logic useImm,
    output logic isBne,
    output busPkg::addrT pc,
    input wire isaPkg::wordT aluResult,
    input wire branchTaken,
    input wire busPkg::addrT branchTarget
);

    import isaPkg::*;
    import busPkg::*;

    typedef enum logic [2:0] {
        stateIdle,
        stateFetch,
        stateDecode,
        stateExecute,
        stateMemory,
        stateWriteback,
        stateHalt
    } cpuStateT;

    cpuStateT state;
    cpuStateT finishState;

    wordT instr;
    wordT aluReg;
    wordT loadWord;
    opcodeT opcode;
    functT funct;
    regIdxT rdIdx;

    logic isLoad;
    logic isStore;
    logic isByte;
    logic isBranch;
    logic isJump;
    logic isJr;
    logic writesReg;

    logic [$clog2(wordLanes)-1:0] byteLane;
    logic [7:0] loadByte;
    addrT pcPlus4;
    addrT jumpTarget;
    addrT nextPc;

    // Instruction fields, stable from decode to the end of the instruction
    assign opcode = opcodeT'(instr[31:26]);
    assign funct = functT'(instr[5:0]);
    assign rsIdx = instr[25:21];
    assign rtIdx = instr[20:16];
    assign rdIdx = instr[15:11];
    assign shamt = instr[10:6];
    assign immediate = instr[15:0];

    assign isLoad = (opcode == opLw) || (opcode == opLbu);
    assign isStore = (opcode == opSw) || (opcode == opSb);
    assign isByte = (opcode == opLbu) || (opcode == opSb);
    assign isBranch = (opcode == opBeq) || (opcode == opBne);
    assign isBne = opcode == opBne;
    assign isJump = opcode == opJ;
    assign isJr = (opcode == opSpecial) && (funct == fnJr);
    assign useImm = opcode != opSpecial;
    // Logical immediates are zero extended
    assign signedImm = !(opcode inside {opAndi, opOri, opXori});

    always_comb begin
        aluOp = aluPassB;
        writesReg = 1'b1;
        case (opcode)
            opSpecial: begin
                case (funct)
                    fnAddu: aluOp = aluAdd;
                    fnSubu: aluOp = aluSub;
                    fnAnd: aluOp = aluAnd;
                    fnOr: aluOp = aluOr;
                    fnXor: aluOp = aluXor;
                    fnSlt: aluOp = aluSlt;
                    fnSltu: aluOp = aluSltu;
                    fnSll: aluOp = aluSll;
                    fnSrl: aluOp = aluSrl;
                    fnSra: aluOp = aluSra;
                    default: writesReg = 1'b0;
                endcase
            end
            opAddiu, opLw, opLbu: aluOp = aluAdd;
            opSw, opSb: begin
                aluOp = aluAdd;
                writesReg = 1'b0;
            end
            opSlti: aluOp = aluSlt;
            opSltiu: aluOp = aluSltu;
            opAndi: aluOp = aluAnd;
            opOri: aluOp = aluOr;
            opXori: aluOp = aluXor;
            opLui: aluOp = aluLui;
            default: writesReg = 1'b0;
        endcase
    end

    // Next PC, no delay slot
    assign pcPlus4 = pc + addrT'(4);
    assign jumpTarget = {pcPlus4[31:28], instr[25:0], 2'b00};

    always_comb begin
        nextPc = pcPlus4;
        if (isJump)
            nextPc = jumpTarget;
        else if (isJr)
            nextPc = rsData;
        else if (isBranch && branchTaken)
            nextPc = branchTarget;
    end

    assign finishState = (nextPc == haltAddress) ? stateHalt : stateFetch;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stateIdle;
            pc <= resetVector;
        end else begin
            case (state)
                stateIdle: state <= stateFetch;
                stateFetch: if (!waitrequest) state <= stateDecode;
                // Register file settles on the new rs and rt
                stateDecode: state <= stateExecute;
                stateExecute: begin
                    if (isLoad || isStore) begin
                        state <= stateMemory;
                    end else if (writesReg) begin
                        state <= stateWriteback;
                    end else begin
                        pc <= nextPc;
                        state <= finishState;
                    end
                end
                stateMemory: begin
                    if (!waitrequest && isLoad) begin
                        state <= stateWriteback;
                    end else if (!waitrequest) begin
                        pc <= nextPc;
                        state <= finishState;
                    end
                end
                stateWriteback: begin
                    pc <= nextPc;
                    state <= finishState;
                end
                stateHalt: state <= stateHalt;
                default: state <= stateIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == stateFetch && !waitrequest)
            instr <= readdata;
        if (state == stateExecute)
            aluReg <= aluResult;
        if (state == stateMemory && !waitrequest)
            loadWord <= readdata;
    end

    assign active = state != stateHalt;

    // Bus master, all outputs come from registers so they hold under waitrequest
    assign byteLane = aluReg[1:0];
    assign read = (state == stateFetch) || ((state == stateMemory) && isLoad);
    assign write = (state == stateMemory) && isStore;
    assign address = (state == stateMemory) ? {aluReg[31:2], 2'b00} : pc;
    assign writedata = isByte ? {wordLanes{rtData[7:0]}} : rtData;
    assign byteenable = ((state == stateMemory) && isByte) ? byteEnT'(1'b1) << byteLane : '1;

    // Write-back source
    assign loadByte = loadWord[8*byteLane +: 8];
    assign writeEnable = state == stateWriteback;
    assign writeIdx = (opcode == opSpecial) ? rdIdx : rtIdx;
    assign writeData = !isLoad ? aluReg : (isByte ? {24'b0, loadByte} : loadWord);

endmodule

`default_nettype wire

// File: logic/executeUnit.sv
`default_nettype none

module executeUnit (
    input wire isaPkg::aluOpT aluOp,
    input wire isaPkg::wordT rsData,
    input wire isaPkg::wordT rtData,
    input wire isaPkg::immT immediate,
    input wire isaPkg::shamtT shamt,
    input wire signedImm,
    input wire useImm,
    input wire busPkg::addrT pc,
    input wire isBne,
    output isaPkg::wordT aluResult,
    output logic branchTaken,
    output busPkg::addrT branchTarget
);

    import isaPkg::*;

    wordT immExt;
    wordT operandB;
    wordT branchOffset;

    // Sign or zero extension of the 16-bit immediate
    assign immExt = signedImm ? {{16{immediate[15]}}, immediate} : {16'b0, immediate};
    assign operandB = useImm ? immExt : rtData;

    always_comb begin
        case (aluOp)
            aluAdd: aluResult = rsData + operandB;
            aluSub: aluResult = rsData - operandB;
            aluAnd: aluResult = rsData & operandB;
            aluOr: aluResult = rsData | operandB;
            aluXor: aluResult = rsData ^ operandB;
            aluSlt: aluResult = wordT'($signed(rsData) < $signed(operandB));
            aluSltu: aluResult = wordT'(rsData < operandB);
            // Shift instructions take rt as operand B
            aluSll: aluResult = operandB << shamt;
            aluSrl: aluResult = operandB >> shamt;
            aluSra: aluResult = $signed(operandB) >>> shamt;
            aluLui: aluResult = {immediate, 16'b0};
            default: aluResult = operandB;
        endcase
    end

    // beq and bne share the equality compare
    assign branchTaken = (rsData == rtData) ^ isBne;

    // Word offset relative to the following instruction
    assign branchOffset = {{14{immediate[15]}}, immediate, 2'b00};
    assign branchTarget = pc + 32'd4 + branchOffset;

endmodule

`default_nettype wire

// File: logic/registerFile.sv
`default_nettype none

module registerFile (
    input wire clk,
    input wire reset,
    input wire isaPkg::regIdxT rsIdx,
    input wire isaPkg::regIdxT rtIdx,
    output isaPkg::wordT rsData,
    output isaPkg::wordT rtData,
    input wire writeEnable,
    input wire isaPkg::regIdxT writeIdx,
    input wire isaPkg::wordT writeData,
    output isaPkg::wordT registerV0
);

    import isaPkg::*;

    wordT regs [regCount];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (writeIdx != '0)) begin
            // Register zero is hardwired
            regs[writeIdx] <= writeData;
        end
    end

    // Asynchronous read ports
    assign rsData = (rsIdx == '0) ? '0 : regs[rsIdx];
    assign rtData = (rtIdx == '0) ? '0 : regs[rtIdx];

    // Result tap for the halted core
    assign registerV0 = regs[regV0];

endmodule

`default_nettype wire

// File: logic/busPkg.sv
`default_nettype none

package busPkg;

    localparam int addrWidth = 32;

    // Byte lanes per data word, little-endian
    localparam int wordLanes = 4;

    typedef logic [addrWidth-1:0] addrT;
    typedef logic [wordLanes-1:0] byteEnT;

    // First fetch after reset
    localparam addrT resetVector = 32'hBFC0_0000;

    // Control transfer here stops the core
    localparam addrT haltAddress = '0;

endpackage

`default_nettype wire

// File: logic/isaPkg.sv
`default_nettype none

package isaPkg;

    // Instruction field widths
    localparam int wordWidth = 32;
    localparam int regIdxWidth = 5;
    localparam int immWidth = 16;
    localparam int opcodeWidth = 6;
    localparam int functWidth = 6;
    localparam int regCount = 1 << regIdxWidth;

    typedef logic [wordWidth-1:0] wordT;
    typedef logic [regIdxWidth-1:0] regIdxT;
    typedef logic [$clog2(wordWidth)-1:0] shamtT;
    typedef logic [immWidth-1:0] immT;

    // Return value register
    localparam regIdxT regV0 = 5'd2;

    typedef enum logic [opcodeWidth-1:0] {
        opSpecial = 6'd0,
        opJ = 6'd2,
        opBeq = 6'd4,
        opBne = 6'd5,
        opAddiu = 6'd9,
        opSlti = 6'd10,
        opSltiu = 6'd11,
        opAndi = 6'd12,
        opOri = 6'd13,
        opXori = 6'd14,
        opLui = 6'd15,
        opLw = 6'd35,
        opLbu = 6'd36,
        opSb = 6'd40,
        opSw = 6'd43
    } opcodeT;

    // Function field of SPECIAL instructions
    typedef enum logic [functWidth-1:0] {
        fnSll = 6'd0,
        fnSrl = 6'd2,
        fnSra = 6'd3,
        fnJr = 6'd8,
        fnAddu = 6'd33,
        fnSubu = 6'd35,
        fnAnd = 6'd36,
        fnOr = 6'd37,
        fnXor = 6'd38,
        fnSlt = 6'd42,
        fnSltu = 6'd43
    } functT;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSltu,
        aluSll,
        aluSrl,
        aluSra,
        aluLui,
        aluPassB
    } aluOpT;

endpackage

`default_nettype wire
